// File: aesDecTop.f
+incdir+.
aesDecPkg.sv
aesInvMixColumns.sv
aesDecDatapath.sv
aesInvKeySchedule.sv
aesDecCtrl.sv
aesDecTop.sv
aesDec_props.sv
aesDecChecker.sv
tbAesDec.sv

// File: Bender.yml
package:
  name: aesDec

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - aesDecPkg.sv
      - aesInvMixColumns.sv
      - aesDecDatapath.sv
      - aesInvKeySchedule.sv
      - aesDecCtrl.sv
      - aesDecTop.sv
  - target: test
    include_dirs:
      - .
    files:
      - aesDec_props.sv
      - aesDecChecker.sv
      - tbAesDec.sv

// File: tbAesDec.sv
// --------------------
// AES-128 decryption engine testbench
// Known vector, random pairs, busy start, output hold, reset abort
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "aesDec_params.svh"

module tbAesDec import aesDecPkg::*; ();

    localparam aesBlockT FIPS_KEY = 128'h13111d7fe3944a17f307a78b4d2b30c5;
    localparam aesBlockT FIPS_CT  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
    localparam aesBlockT FIPS_PT  = 128'h00112233445566778899aabbccddeeff;
    localparam int       TIMEOUT  = 40;  // Cycles, well over the latency

    logic         CLK;
    logic         RST;
    logic         start;
    aesBlockT     cipherText, decKey, plainText, expected;
    logic         done, busy;
    logic [127:0] testName;
    int           chkErrors, doneCount, tbErrors, doneBase, total;
    logic [31:0]  seedQ;
    aesBlockT     ct, key, holdVal;

    always #50 CLK = ~CLK;  // 100 ns period

    aesDecTop u_dut (
        .CLK(CLK), .RST(RST), .start(start), .cipherText(cipherText),
        .decKey(decKey), .plainText(plainText), .done(done), .busy(busy)
    );

    aesDecChecker uChk (
        .CLK(CLK), .RST(RST), .start(start), .busy(busy), .done(done),
        .expected(expected), .plainText(plainText), .testName(testName),
        .errorCount(chkErrors), .doneCount(doneCount)
    );

    // --------------------
    // Reference model
    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Generic shift-and-add GF(2^8) product
    function automatic logic [7:0] gfMul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] p;
        p = 8'h00;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) p = p ^ a;
            a = {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
        end
        return p;
    endfunction

    // Standard inverse cipher, byte n is row n%4 of column n/4
    function automatic aesBlockT aesDecRef(input aesBlockT ctIn, input aesBlockT keyIn);
        logic [31:0] w [44];
        logic [7:0]  rc [11];
        logic [7:0]  s [16];
        logic [7:0]  u [16];
        logic [31:0] t;
        aesBlockT    res;
        rc[1] = 8'h01;
        for (int i = 2; i <= 10; i++) rc[i] = gfMul(rc[i-1], 8'h02);
        for (int i = 0; i < 4; i++) w[40+i] = keyIn[127-32*i -: 32];
        for (int i = 39; i >= 0; i--) begin  // Undo w[i+4] = w[i] ^ f(w[i+3])
            t = w[i+3];
            if (i % 4 == 0)
                t = {sBox(t[23:16]), sBox(t[15:8]), sBox(t[7:0]), sBox(t[31:24])}
                    ^ {rc[i/4+1], 24'h0};
            w[i] = w[i+4] ^ t;
        end
        for (int n = 0; n < 16; n++) s[n] = ctIn[127-8*n -: 8] ^ w[40+n/4][31-8*(n%4) -: 8];
        for (int rnd = 9; rnd >= 0; rnd--) begin
            for (int n = 0; n < 16; n++)  // InvShiftRows, InvSubBytes, AddRoundKey
                u[n] = invSBox(s[n%4 + 4*((n/4 - n%4 + 4) % 4)])
                       ^ w[4*rnd+n/4][31-8*(n%4) -: 8];
            for (int c = 0; c < 4; c++) begin
                for (int r = 0; r < 4; r++) begin
                    if (rnd == 0) s[4*c+r] = u[4*c+r];
                    else s[4*c+r] = gfMul(u[4*c+r], 8'h0e) ^ gfMul(u[4*c+(r+1)%4], 8'h0b)
                                  ^ gfMul(u[4*c+(r+2)%4], 8'h0d) ^ gfMul(u[4*c+(r+3)%4], 8'h09);
                end
            end
        end
        for (int n = 0; n < 16; n++) res[127-8*n -: 8] = s[n];
        return res;
    endfunction

    // --------------------
    // Stimulus tasks
    task automatic randomBlock(output aesBlockT b);
        for (int i = 0; i < 4; i++) begin
            seedQ = lcgNext(seedQ);
            b[127-32*i -: 32] = seedQ;
        end
    endtask

    task automatic requestDecrypt(input aesBlockT c, input aesBlockT k, input aesBlockT exp,
                                  input logic [127:0] name);
        @(posedge CLK);
        #1;
        start      = 1'b1;
        cipherText = c;
        decKey     = k;
        expected   = exp;
        testName   = name;
        @(posedge CLK);
        #1 start = 1'b0;
    endtask

    task automatic waitForDone(input logic [127:0] name);
        int n;
        n = 0;
        while (!done && n < TIMEOUT) begin
            @(negedge CLK);  // Outputs settled
            n++;
        end
        if (!done) begin
            tbErrors++;
            $display("Timeout: done never came for test %0s", name);
        end
    endtask

    // --------------------
    // Test sequence
    initial begin
        CLK        = 1'b0;
        RST        = 1'b0;
        start      = 1'b0;
        cipherText = '0;
        decKey     = '0;
        expected   = '0;
        testName   = '0;
        seedQ      = 32'd14724;
        tbErrors   = 0;
        repeat (8) @(posedge CLK);
        #1 RST = 1'b1;

        if (aesDecRef(FIPS_CT, FIPS_KEY) !== FIPS_PT) begin
            tbErrors++;
            $display("Reference model disagrees with the FIPS-197 vector");
        end
        requestDecrypt(FIPS_CT, FIPS_KEY, FIPS_PT, "fips197");
        waitForDone("fips197");

        repeat (20) begin
            randomBlock(ct);
            randomBlock(key);
            requestDecrypt(ct, key, aesDecRef(ct, key), "random");
            waitForDone("random");
        end

        holdVal = expected;  // Result must survive input changes
        repeat (6) begin
            @(posedge CLK);
            #1 randomBlock(cipherText);
            @(negedge CLK);
            if (plainText !== holdVal) begin
                tbErrors++;
                $display("Fail holdOut: expected %h actual %h", holdVal, plainText);
            end
        end

        randomBlock(ct);
        randomBlock(key);
        doneBase = doneCount;
        requestDecrypt(ct, key, aesDecRef(ct, key), "busyStart");
        repeat (3) @(posedge CLK);
        #1 start = 1'b1;  // Second request, must be ignored
        randomBlock(cipherText);
        @(posedge CLK);
        #1 start = 1'b0;
        waitForDone("busyStart");
        repeat (15) @(negedge CLK);
        if (doneCount - doneBase != 1) begin
            tbErrors++;
            $display("Fail busyStart: expected 1 actual %0d", doneCount - doneBase);
        end

        randomBlock(ct);
        randomBlock(key);
        requestDecrypt(ct, key, aesDecRef(ct, key), "resetAbort");
        repeat (5) @(posedge CLK);
        #1 RST = 1'b0;  // Abort mid-run
        @(negedge CLK);
        if (busy || done) begin
            tbErrors++;
            $display("busy or done stayed high after reset was applied");
        end
        repeat (2) @(posedge CLK);
        #1 RST = 1'b1;
        doneBase = doneCount;
        repeat (20) @(negedge CLK);
        if (doneCount != doneBase) begin
            tbErrors++;
            $display("done arrived after the request was aborted by reset");
        end
        randomBlock(ct);
        randomBlock(key);
        requestDecrypt(ct, key, aesDecRef(ct, key), "afterReset");
        waitForDone("afterReset");

        repeat (2) @(posedge CLK);
        total = chkErrors + tbErrors + u_dut.uProps.failCount;
        $display("Errors: checker %0d, testbench %0d, assertions %0d",
                 chkErrors, tbErrors, u_dut.uProps.failCount);
        if (total == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: aesDecChecker.sv
// --------------------
// AES decryption result checker
// Models busy, queues expected plaintext on accepted start, compares on done
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "aesDec_params.svh"

module aesDecChecker import aesDecPkg::*; (
    input  logic         CLK,
    input  logic         RST,
    input  logic         start,
    input  logic         busy,
    input  logic         done,
    input  aesBlockT     expected,    // Reference result, valid with start
    input  aesBlockT     plainText,
    input  logic [127:0] testName,    // Up to 16 characters
    output int           errorCount,
    output int           doneCount
);

    localparam longint LATENCY = `AES_ROUNDS + 2;  // Load, 11 rounds
    localparam int     RUN_LEN = `AES_ROUNDS + 1;  // Busy cycles, rounds 10 to 0

    aesBlockT     expQ [$];
    logic [127:0] nameQ [$];
    longint       startQ [$];
    longint       cycle;
    aesBlockT     expV;
    logic [127:0] nameV;
    longint       startV;
    int           runLeft;    // Busy cycles still due
    logic         busyExp;

    initial begin
        errorCount = 0;
        doneCount  = 0;
        cycle      = 0;
        runLeft    = 0;
    end

    // --------------------
    // Compare on done, then take new request
    always @(posedge CLK or negedge RST) begin
        if (!RST) begin
            expQ.delete();      // Aborted requests never finish
            nameQ.delete();
            startQ.delete();
            runLeft = 0;
        end else begin
            cycle++;
            busyExp = (runLeft != 0);
            if (busy !== busyExp) begin
                errorCount++;
                $display("Fail %0s busy: expected %0b actual %0b", testName, busyExp, busy);
            end
            if (done) begin
                doneCount++;
                if (expQ.size() == 0) begin
                    errorCount++;
                    $display("done pulsed with no request pending at %0t", $time);
                end else begin
                    expV   = expQ.pop_front();
                    nameV  = nameQ.pop_front();
                    startV = startQ.pop_front();
                    if (plainText !== expV) begin
                        errorCount++;
                        $display("Fail %0s: expected %h actual %h", nameV, expV, plainText);
                    end
                    if (cycle - startV != LATENCY) begin
                        errorCount++;
                        $display("Fail %0s latency: expected %0d actual %0d",
                                 nameV, LATENCY, cycle - startV);
                    end
                end
            end
            if (start && !busyExp) begin   // Start while busy is dropped
                expQ.push_back(expected);
                nameQ.push_back(testName);
                startQ.push_back(cycle);
                runLeft = RUN_LEN;
            end else if (runLeft != 0) begin
                runLeft--;
            end
        end
    end

endmodule

`default_nettype wire

// File: aesDec_props.sv
// --------------------
// AES decryption protocol assertions
// Bound to the top level, checks done pulse and latency
// --------------------
`timescale 1ns/1ps
`default_nettype none

module aesDecProps (
    input logic CLK,
    input logic RST,
    input logic start,
    input logic busy,
    input logic done
);

    int failCount = 0;  // Read by the testbench

    // done is a single-cycle pulse
    donePulse: assert property (@(posedge CLK) disable iff (!RST) done |=> !done)
        else begin
            failCount++;
            $error("done stayed high for more than one cycle");
        end

    // Accepted start, then 11 quiet cycles, then done
    doneLatency: assert property (@(posedge CLK) disable iff (!RST)
        (start && !busy) |=> (!done) [*11] ##1 done)
        else begin
            failCount++;
            $error("done did not arrive exactly 12 cycles after start");
        end

    // Engine idle while in reset
    idleInReset: assert property (@(posedge CLK) !RST |-> (!busy && !done))
        else begin
            failCount++;
            $error("busy or done high during reset");
        end

endmodule

bind aesDecTop aesDecProps uProps (
    .CLK   (CLK),
    .RST   (RST),
    .start (start),
    .busy  (busy),
    .done  (done)
);

`default_nettype wire

// File: aesDecTop.sv
// --------------------
// AES-128 decryption engine top
// Controller, inverse key schedule and round datapath
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "aesDec_params.svh"

module aesDecTop import aesDecPkg::*; (
    input  logic     CLK,
    input  logic     RST,
    input  logic     start,       // One-cycle request
    input  aesBlockT cipherText,
    input  aesBlockT decKey,      // Round-10 key
    output aesBlockT plainText,
    output logic     done,        // Result valid pulse
    output logic     busy
);

    decCtrlT  ctrl;
    aesBlockT roundKey;

    aesDecCtrl uCtrl (
        .CLK   (CLK),
        .RST   (RST),
        .start (start),
        .ctrl  (ctrl),
        .busy  (busy)
    );

    aesInvKeySchedule uKey (
        .CLK      (CLK),
        .RST      (RST),
        .ctrl     (ctrl),
        .decKey   (decKey),
        .roundKey (roundKey)
    );

    aesDecDatapath uDp (
        .CLK        (CLK),
        .RST        (RST),
        .ctrl       (ctrl),
        .cipherText (cipherText),
        .roundKey   (roundKey),
        .plainText  (plainText),
        .done       (done)
    );

endmodule

`default_nettype wire

// File: aesDecCtrl.sv
// --------------------
// AES decryption controller
// Accepts start, issues load and counts rounds 10 down to 0
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "aesDec_params.svh"

module aesDecCtrl import aesDecPkg::*; (
    input  logic    CLK,
    input  logic    RST,
    input  logic    start,
    output decCtrlT ctrl,
    output logic    busy
);

    ctrlStateT stateQ;
    roundNumT  roundQ;

    // --------------------
    // FSM and round counter
    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            stateQ <= idle;
            roundQ <= '0;
        end else begin
            case (stateQ)
                idle: begin
                    if (start) begin
                        stateQ <= run;
                        roundQ <= roundNumT'(`AES_ROUNDS);  // First round is 10
                    end
                end
                run: begin
                    if (roundQ == '0) begin
                        stateQ <= idle;        // Round 0 done
                    end else begin
                        roundQ <= roundQ - 1'b1;
                    end
                end
                default: stateQ <= idle;
            endcase
        end
    end

    // Load straight from start, start while busy is dropped
    assign ctrl = '{
        load:     (stateQ == idle) && start,
        roundEn:  (stateQ == run),
        roundNum: roundQ
    };

    assign busy = (stateQ == run);

endmodule

`default_nettype wire

// File: aesInvKeySchedule.sv
// --------------------
// AES-128 inverse key schedule
// Steps from the round-10 key back to key 0, one key per round
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "aesDec_params.svh"

module aesInvKeySchedule import aesDecPkg::*; (
    input  logic     CLK,
    input  logic     RST,
    input  decCtrlT  ctrl,
    input  aesBlockT decKey,     // Last encryption round key
    output aesBlockT roundKey    // Key for ctrl.roundNum
);

    aesBlockT    keyQ, keyPrev;
    logic [31:0] k0, k1, k2, k3;  // Words of key r
    logic [31:0] p0, p1, p2, p3;  // Words of key r-1
    logic [31:0] rotSub;
    logic        stepKey;

    assign {k0, k1, k2, k3} = keyQ;

    // --------------------
    // Undo the forward recurrence
    assign p3 = k3 ^ k2;
    assign p2 = k2 ^ k1;
    assign p1 = k1 ^ k0;

    // SubWord(RotWord(p3))
    assign rotSub = {sBox(p3[23:16]), sBox(p3[15:8]), sBox(p3[7:0]), sBox(p3[31:24])};

    assign p0 = k0 ^ rotSub ^ {rCon(ctrl.roundNum), 24'h000000};

    assign keyPrev = {p0, p1, p2, p3};

    // Key 0 stays put for round 0
    assign stepKey = ctrl.roundEn && (ctrl.roundNum != '0);

    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            keyQ <= '0;
        end else if (ctrl.load) begin
            keyQ <= decKey;
        end else if (stepKey) begin
            keyQ <= keyPrev;    // Ready for next round
        end
    end

    assign roundKey = keyQ;

endmodule

`default_nettype wire

// File: aesDecDatapath.sv
// --------------------
// AES iterative inverse-round datapath
// One inverse round per cycle on a held state register
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "aesDec_params.svh"

module aesDecDatapath import aesDecPkg::*; (
    input  logic     CLK,
    input  logic     RST,
    input  decCtrlT  ctrl,
    input  aesBlockT cipherText,
    input  aesBlockT roundKey,    // Key for ctrl.roundNum
    output aesBlockT plainText,
    output logic     done
);

    localparam int NBYTES = `AES_BLOCK_BITS / 8;
    localparam int MSB    = `AES_BLOCK_BITS - 1;

    aesBlockT stateQ;
    aesBlockT addKey, mixOut, shiftIn, shiftOut, subOut, stateNext;
    logic     firstRound, lastRound;

    assign firstRound = (ctrl.roundNum == roundNumT'(`AES_ROUNDS));
    assign lastRound  = (ctrl.roundNum == '0);

    assign addKey = stateQ ^ roundKey;  // AddRoundKey

    aesInvMixColumns uMix (.in(addKey), .out(mixOut));

    assign shiftIn = firstRound ? addKey : mixOut;  // No InvMixColumns in round 10

    // --------------------
    // InvShiftRows then InvSubBytes
    always_comb begin
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                // Row r rotates right by r
                shiftOut[MSB-8*(4*c+r) -: 8] = shiftIn[MSB-8*(4*((c-r+4)%4)+r) -: 8];
            end
        end
        for (int i = 0; i < NBYTES; i++) begin
            subOut[MSB-8*i -: 8] = invSBox(shiftOut[MSB-8*i -: 8]);
        end
    end

    assign stateNext = lastRound ? addKey : subOut;  // Round 0 is key addition only

    // --------------------
    // State register
    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            stateQ <= '0;
        end else if (ctrl.load) begin
            stateQ <= cipherText;          // New block
        end else if (ctrl.roundEn) begin
            stateQ <= stateNext;
        end                                // Else hold result
    end

    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            done <= 1'b0;
        end else begin
            done <= ctrl.roundEn && lastRound;  // Idle round 0 must not fire
        end
    end

    assign plainText = stateQ;

endmodule

`default_nettype wire

// File: aesInvMixColumns.sv
// --------------------
// AES inverse MixColumns
// GF(2^8) matrix {0e,0b,0d,09} applied to every column
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "aesDec_params.svh"

module aesInvMixColumns import aesDecPkg::*; (
    input  aesBlockT in,
    output aesBlockT out
);

    localparam int NCOLS = `AES_BLOCK_BITS / 32;

    // Multiply by x modulo the AES polynomial
    function automatic logic [7:0] xtime(input logic [7:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    // One column, row 0 in the top byte
    function automatic logic [31:0] invMixCol(input logic [31:0] col);
        logic [7:0] a [4];
        logic [7:0] m9 [4];
        logic [7:0] m11 [4];
        logic [7:0] m13 [4];
        logic [7:0] m14 [4];
        logic [7:0] x2, x4, x8;
        for (int r = 0; r < 4; r++) begin
            a[r]   = col[31-8*r -: 8];
            x2     = xtime(a[r]);     // 2a
            x4     = xtime(x2);       // 4a
            x8     = xtime(x4);       // 8a
            m9[r]  = x8 ^ a[r];
            m11[r] = x8 ^ x2 ^ a[r];
            m13[r] = x8 ^ x4 ^ a[r];
            m14[r] = x8 ^ x4 ^ x2;
        end
        return {m14[0] ^ m11[1] ^ m13[2] ^ m9[3],
                m9[0] ^ m14[1] ^ m11[2] ^ m13[3],
                m13[0] ^ m9[1] ^ m14[2] ^ m11[3],
                m11[0] ^ m13[1] ^ m9[2] ^ m14[3]};
    endfunction

    // Columns are independent
    for (genvar c = 0; c < NCOLS; c++) begin : gCol
        assign out[`AES_BLOCK_BITS-1-32*c -: 32] = invMixCol(in[`AES_BLOCK_BITS-1-32*c -: 32]);
    end

endmodule

`default_nettype wire

// File: aesDecPkg.sv
// --------------------
// AES decryption shared types
// Block, control and FSM types plus S-box and round-constant lookups
// --------------------
`default_nettype none

`include "aesDec_params.svh"

package aesDecPkg;

    typedef logic [`AES_BLOCK_BITS-1:0] aesBlockT;  // State, key or text
    typedef logic [`AES_ROUND_BITS-1:0] roundNumT;  // Round 10 down to 0

    // Controller to datapath and key schedule
    typedef struct packed {
        logic     load;      // Take new block and key
        logic     roundEn;   // One inverse round this cycle
        roundNumT roundNum;  // Round being performed
    } decCtrlT;

    typedef enum logic {
        idle,  // Waiting for start
        run    // Rounds in progress
    } ctrlStateT;

    // --------------------
    // Forward S-box, byte 0 first
    localparam logic [0:255][7:0] SBOX_TAB = {
        128'h637c777bf26b6fc53001672bfed7ab76,
        128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115,
        128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84,
        128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8,
        128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973,
        128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479,
        128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
        128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df,
        128'h8ca1890dbfe6426841992d0fb054bb16
    };

    // --------------------
    // Inverse S-box, byte 0 first
    localparam logic [0:255][7:0] INV_SBOX_TAB = {
        128'h52096ad53036a538bf40a39e81f3d7fb,
        128'h7ce339829b2fff87348e4344c4dee9cb,
        128'h547b9432a6c2233dee4c950b42fac34e,
        128'h082ea16628d924b2765ba2496d8bd125,
        128'h72f8f66486689816d4a45ccc5d65b692,
        128'h6c704850fdedb9da5e154657a78d9d84,
        128'h90d8ab008cbcd30af7e45805b8b34506,
        128'hd02c1e8fca3f0f02c1afbd0301138a6b,
        128'h3a9111414f67dcea97f2cfcef0b4e673,
        128'h96ac7422e7ad3585e2f937e81c75df6e,
        128'h47f11a711d29c5896fb7620eaa18be1b,
        128'hfc563e4bc6d279209adbc0fe78cd5af4,
        128'h1fdda8338807c731b11210592780ec5f,
        128'h60517fa919b54a0d2de57a9f93c99cef,
        128'ha0e03b4dae2af5b0c8ebbb3c83539961,
        128'h172b047eba77d626e169146355210c7d
    };

    // Key schedule SubWord byte
    function automatic logic [7:0] sBox(input logic [7:0] b);
        return SBOX_TAB[b];
    endfunction

    // InvSubBytes byte
    function automatic logic [7:0] invSBox(input logic [7:0] b);
        return INV_SBOX_TAB[b];
    endfunction

    // Round constant that produced key r from key r-1
    function automatic logic [7:0] rCon(input roundNumT r);
        case (r)
            4'd1:    return 8'h01;
            4'd2:    return 8'h02;
            4'd3:    return 8'h04;
            4'd4:    return 8'h08;
            4'd5:    return 8'h10;
            4'd6:    return 8'h20;
            4'd7:    return 8'h40;
            4'd8:    return 8'h80;
            4'd9:    return 8'h1b;
            4'd10:   return 8'h36;
            default: return 8'h00;  // Round 0 has no constant
        endcase
    endfunction

endpackage

`default_nettype wire

// File: aesDec_params.svh
// --------------------
// AES decryption core sizes
// Block width, round count and round-number width
// --------------------
`ifndef AES_DEC_PARAMS_SVH
`define AES_DEC_PARAMS_SVH

// Block and key width for AES-128
`define AES_BLOCK_BITS 128

// Rounds for a 128-bit key
`define AES_ROUNDS 10

// Holds 0 to AES_ROUNDS
`define AES_ROUND_BITS 4

`endif
